//--- console_link.f
verilog/com_proto_pkg.sv
verilog/com_ctrl_pkg.sv
verilog/frame_parser.sv
verilog/cmd_fifo.sv
verilog/reply_builder.sv
verilog/frame_sender.sv
verilog/console_com.sv
verilog/console_link.sv
sim/console_link_sva.sv
sim/console_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
log=sim_run.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module console_link_tb -f console_link.f -o console_link_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/console_link_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
exit 0

//--- sim/console_link_golden.txt
// mode rx0 rx1 rx2 reply state   (mode 0 single frame, 1 burst frame, reply 100 means none)
// state is the expected com_state after the line or burst: 0 idle, 1 conf, 2 read, 3 same
0 A5 01 FE 001 3
0 A5 12 EE 100 3
0 5A 12 ED 100 3
0 A5 63 9C 100 3
0 A5 12 ED 012 0
0 A5 37 C8 037 0
0 A5 24 DB 044 3
0 A5 46 B9 100 0
0 A5 53 AC 100 0
1 A5 01 FE 001 0
1 A5 15 EA 015 0
1 A5 22 DD 042 0
1 A5 33 CC 033 0
0 A5 2B D4 05B 3
1 A5 03 FC 003 0
1 A5 14 EB 014 0
1 A5 2E D1 04E 0
1 A5 35 CA 035 0
1 A5 10 EF 010 0
1 A5 09 F6 100 0

//--- sim/console_link_sva.sv
module console_link_sva (
    input logic                      clk,
    input logic                      rst,
    input logic                      fs_com_read,
    input logic                      fd_com_read,
    input logic                      fs_read,
    input logic                      fd_read,
    input logic                      fs_com_send,
    input com_ctrl_pkg::ctrl_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;

    read_done_after_request: assert property (
        @(posedge clk) disable iff (rst) fd_com_read |-> $past(fs_com_read)
    ) else $error("fd_com_read without a preceding fs_com_read");

    // the sender is never asked while a read exchange with the reply builder is open
    no_send_during_read: assert property (
        @(posedge clk) disable iff (rst) !(fs_com_send && (fs_read || fd_read))
    ) else $error("fs_com_send is high during a read exchange");

    state_one_hot: assert property (
        @(posedge clk) disable iff (rst) $onehot(state)
    ) else $error("controller state is not one-hot");

endmodule

bind console_com console_link_sva u_sva (
    .clk(clk), .rst(rst), .fs_com_read(fs_com_read), .fd_com_read(fd_com_read),
    .fs_read(fs_read), .fd_read(fd_read), .fs_com_send(fs_com_send), .state(state)
);

//--- sim/console_link_tb.sv
module console_link_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          fifo_depth     = 4;
    localparam int          byte_gap       = 8;
    localparam int          timeout_cycles = 400;
    localparam int          max_lines      = 32;
    localparam logic [11:0] no_reply       = 12'h100;
    localparam logic [7:0]  sync_byte      = 8'hA5;

    logic                     clk;
    logic                     rst;
    logic                     rx_valid;
    logic [7:0]               rx_byte;
    logic                     tx_valid;
    logic [7:0]               tx_byte;
    com_ctrl_pkg::com_state_e com_state;

    logic [11:0] golden [6*max_lines];  // six words per line of the golden file
    logic [7:0]  tx_q [$];
    int          gap_q [$];
    int          idle_run;
    int          errors;
    int          timeouts;
    int          n_lines;
    int          line_idx;
    int          group_end;

    console_link #(.fifo_depth(fifo_depth), .byte_gap(byte_gap)) uut (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .tx_valid(tx_valid), .tx_byte(tx_byte), .com_state(com_state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // collects every tx byte with the idle cycles that came before it
    always @(negedge clk) begin
        if (tx_valid) begin
            tx_q.push_back(tx_byte);
            gap_q.push_back(idle_run);
            idle_run = 0;
        end else begin
            idle_run++;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send_frame(input int line, input logic burst);
        int idle;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            rx_valid <= 1'b1;
            rx_byte  <= golden[6*line + 1 + i][7:0];
            idle = (burst || i == 2) ? 0 : int'($urandom % 4);
            repeat (idle) begin
                @(posedge clk);
                rx_valid <= 1'b0;
            end
        end
    endtask

    task automatic release_rx;
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    task automatic expect_reply(input logic [7:0] cmd);
        int         waited;
        logic [7:0] inv;
        waited = 0;
        inv    = ~cmd;
        while (tx_q.size() < 3 && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (tx_q.size() < 3) begin
            timeouts++;
            $display("no reply frame within timeout for reply %02h at time %0t", cmd, $time);
            tx_q.delete();
            gap_q.delete();
        end else begin
            check_value("tx_byte", tx_q.pop_front(), sync_byte);
            void'(gap_q.pop_front());  // gap before a sync byte depends on the traffic
            check_value("tx_byte", tx_q.pop_front(), cmd);
            check_value("tx idle gap", gap_q.pop_front(), byte_gap);
            check_value("tx_byte", tx_q.pop_front(), inv);
            check_value("tx idle gap", gap_q.pop_front(), byte_gap);
        end
    endtask

    task automatic expect_silence;
        int start_size;
        start_size = tx_q.size();
        repeat (timeout_cycles) @(posedge clk);
        assert (tx_q.size() == start_size) else begin
            errors++;
            $display("a reply frame was sent where none was due, seen by time %0t", $time);
            tx_q.delete();
            gap_q.delete();
        end
    endtask

    task automatic check_state(input logic [1:0] exp);
        repeat (2) @(posedge clk);
        @(negedge clk);  // com_state settles 3 cycles after the last reply byte
        check_value("com_state", com_state, exp);
    endtask

    task automatic run_single(input int line);
        send_frame(line, 1'b0);
        release_rx();
        if (golden[6*line + 4] == no_reply) expect_silence();
        else expect_reply(golden[6*line + 4][7:0]);
        check_state(golden[6*line + 5][1:0]);
    endtask

    task automatic run_burst(input int first, input int last);
        logic dropped;
        dropped = 1'b0;
        for (int l = first; l < last; l++) send_frame(l, 1'b1);
        release_rx();
        for (int l = first; l < last; l++) begin
            if (golden[6*l + 4] == no_reply) dropped = 1'b1;
            else expect_reply(golden[6*l + 4][7:0]);
        end
        check_state(golden[6*(last - 1) + 5][1:0]);
        if (dropped) expect_silence();
    endtask

    initial begin
        void'($urandom(32'h1e99));
        errors   = 0;
        timeouts = 0;
        idle_run = 0;
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_byte  = 8'h00;
        for (int i = 0; i < 6*max_lines; i++) golden[i] = 12'hfff;  // marks the end of the file
        $readmemh("sim/console_link_golden.txt", golden);
        n_lines = 0;
        while (n_lines < max_lines && golden[6*n_lines] != 12'hfff) n_lines++;
        assert (n_lines > 0) else begin
            errors++;
            $display("the golden file holds no stimulus lines");
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("tx_valid", tx_valid, 0);
        check_value("com_state", com_state, 0);

        line_idx = 0;
        while (line_idx < n_lines) begin
            if (golden[6*line_idx] == 12'h000) begin
                run_single(line_idx);
                line_idx++;
            end else begin
                group_end = line_idx;
                while (group_end < n_lines && golden[6*group_end] != 12'h000) group_end++;
                run_burst(line_idx, group_end);
                line_idx = group_end;
            end
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/cmd_fifo.sv
module cmd_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_cmd,
    output logic       fs_com_read,
    input  logic       fd_com_read,
    output logic [7:0] head_cmd
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    logic [7:0]       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push_ok;
    logic             pop;

    assign push_ok  = push && (count != cnt_w'(fifo_depth));  // newest frame is lost when full
    assign pop      = fs_com_read && fd_com_read;
    assign head_cmd = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) mem[wr_ptr] <= push_cmd;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            fs_com_read <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push_ok) - cnt_w'(pop);

            // request drops on the pop and re-arms only once the done has fallen
            if (pop) begin
                fs_com_read <= 1'b0;
            end else if (!fs_com_read && !fd_com_read && (count != '0 || push_ok)) begin
                fs_com_read <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/com_ctrl_pkg.sv
package com_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CONF = 2'b01,
        READ = 2'b10,
        SAME = 2'b11
    } com_state_e;

    // one-hot controller states
    typedef enum logic [9:0] {
        MAIN_IDLE = 10'h001,
        MAIN_WAIT = 10'h002,
        READ_IDLE = 10'h004,
        READ_WAIT = 10'h008,
        READ_WORK = 10'h010,
        READ_DONE = 10'h020,
        SEND_IDLE = 10'h040,
        SEND_WAIT = 10'h080,
        SEND_WORK = 10'h100,
        SEND_DONE = 10'h200
    } ctrl_state_e;

endpackage

//--- verilog/com_proto_pkg.sv
package com_proto_pkg;

    // block type carried in the upper nibble of a command byte
    typedef enum logic [3:0] {
        INIT = 4'h0,
        CONF = 4'h1,
        READ = 4'h2,
        STOP = 4'h3,
        RXD0 = 4'h4,
        RXD1 = 4'h5
    } btype_e;

    localparam logic [7:0] SYNC_BYTE = 8'hA5;  // first byte of every frame in both directions

endpackage

//--- verilog/console_com.sv
module console_com (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fs_send,
    output logic                     fd_send,
    output logic                     fs_read,
    input  logic                     fd_read,
    output logic                     fs_com_send,
    input  logic                     fd_com_send,
    input  logic                     fs_com_read,
    output logic                     fd_com_read,
    input  com_proto_pkg::btype_e    com_btype,
    output com_ctrl_pkg::com_state_e com_state
);

    com_ctrl_pkg::ctrl_state_e state;
    com_ctrl_pkg::ctrl_state_e next_state;

    assign fd_send     = (state == com_ctrl_pkg::SEND_DONE);
    assign fs_read     = (state == com_ctrl_pkg::READ_WAIT);
    assign fs_com_send = (state == com_ctrl_pkg::SEND_WAIT);
    assign fd_com_read = (state == com_ctrl_pkg::READ_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) state <= com_ctrl_pkg::MAIN_IDLE;
        else state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            com_ctrl_pkg::MAIN_IDLE: next_state = com_ctrl_pkg::MAIN_WAIT;
            com_ctrl_pkg::MAIN_WAIT: begin
                if (fs_com_read) next_state = com_ctrl_pkg::READ_IDLE;  // reads win over sends
                else if (fs_send) next_state = com_ctrl_pkg::SEND_IDLE;
            end
            com_ctrl_pkg::READ_IDLE: next_state = com_ctrl_pkg::READ_WORK;
            com_ctrl_pkg::READ_WORK: next_state = com_ctrl_pkg::READ_WAIT;
            com_ctrl_pkg::READ_WAIT: begin
                if (fd_read) next_state = com_ctrl_pkg::READ_DONE;
            end
            com_ctrl_pkg::READ_DONE: begin
                if (!fs_com_read) next_state = com_ctrl_pkg::MAIN_WAIT;
            end
            com_ctrl_pkg::SEND_IDLE: next_state = com_ctrl_pkg::SEND_WAIT;
            com_ctrl_pkg::SEND_WAIT: begin
                if (fd_com_send) next_state = com_ctrl_pkg::SEND_WORK;
            end
            com_ctrl_pkg::SEND_WORK: next_state = com_ctrl_pkg::SEND_DONE;
            com_ctrl_pkg::SEND_DONE: begin
                if (!fs_send) next_state = com_ctrl_pkg::MAIN_IDLE;
            end
            default: next_state = com_ctrl_pkg::MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_state <= com_ctrl_pkg::IDLE;
        end else if (state == com_ctrl_pkg::READ_WORK) begin
            case (com_btype)  // com_btype is the incoming command type here
                com_proto_pkg::CONF: com_state <= com_ctrl_pkg::CONF;
                com_proto_pkg::READ: com_state <= com_ctrl_pkg::READ;
                default:             com_state <= com_ctrl_pkg::IDLE;
            endcase
        end else if (state == com_ctrl_pkg::SEND_WORK) begin
            case (com_btype)  // and the reply type here
                com_proto_pkg::INIT,
                com_proto_pkg::RXD0,
                com_proto_pkg::RXD1: com_state <= com_ctrl_pkg::SAME;
                default:             com_state <= com_ctrl_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- verilog/console_link.sv
module console_link #(
    parameter int fifo_depth = 4,
    parameter int byte_gap   = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_valid,
    input  logic [7:0]               rx_byte,
    output logic                     tx_valid,
    output logic [7:0]               tx_byte,
    output com_ctrl_pkg::com_state_e com_state
);

    logic                  push;
    logic [7:0]            push_cmd;
    logic                  fs_com_read;
    logic                  fd_com_read;
    logic [7:0]            head_cmd;
    logic                  fs_read;
    logic                  fd_read;
    logic                  fs_send;
    logic                  fd_send;
    logic                  fs_com_send;
    logic                  fd_com_send;
    logic [7:0]            reply_cmd;
    com_proto_pkg::btype_e com_btype;

    frame_parser u_parser (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
        .push(push), .push_cmd(push_cmd)
    );

    cmd_fifo #(.fifo_depth(fifo_depth)) u_fifo (
        .clk(clk), .rst(rst), .push(push), .push_cmd(push_cmd),
        .fs_com_read(fs_com_read), .fd_com_read(fd_com_read), .head_cmd(head_cmd)
    );

    console_com u_ctrl (
        .clk(clk), .rst(rst), .fs_send(fs_send), .fd_send(fd_send),
        .fs_read(fs_read), .fd_read(fd_read),
        .fs_com_send(fs_com_send), .fd_com_send(fd_com_send),
        .fs_com_read(fs_com_read), .fd_com_read(fd_com_read),
        .com_btype(com_btype), .com_state(com_state)
    );

    reply_builder u_reply (
        .clk(clk), .rst(rst), .head_cmd(head_cmd), .fs_read(fs_read), .fd_read(fd_read),
        .fs_send(fs_send), .fd_send(fd_send), .com_btype(com_btype), .reply_cmd(reply_cmd)
    );

    frame_sender #(.byte_gap(byte_gap)) u_sender (
        .clk(clk), .rst(rst), .reply_cmd(reply_cmd),
        .fs_com_send(fs_com_send), .fd_com_send(fd_com_send),
        .tx_valid(tx_valid), .tx_byte(tx_byte)
    );

endmodule

//--- verilog/frame_parser.sv
module frame_parser (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [7:0] rx_byte,
    output logic       push,
    output logic [7:0] push_cmd
);

    typedef enum logic [1:0] {
        HUNT      = 2'd0,
        GET_CMD   = 2'd1,
        GET_CHECK = 2'd2
    } phase_e;

    phase_e     phase;
    logic [7:0] cmd_q;
    logic       frame_ok;

    // the check byte must invert the command and the type must be a known one
    assign frame_ok = (rx_byte == ~cmd_q) && (cmd_q[7:4] <= com_proto_pkg::RXD1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= HUNT;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            if (rx_valid) begin
                case (phase)
                    HUNT: begin
                        if (rx_byte == com_proto_pkg::SYNC_BYTE) phase <= GET_CMD;
                    end
                    GET_CMD: phase <= GET_CHECK;
                    GET_CHECK: begin
                        push  <= frame_ok;  // a bad frame just falls back to the hunt
                        phase <= HUNT;
                    end
                    default: phase <= HUNT;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && phase == GET_CMD) cmd_q <= rx_byte;
        if (rx_valid && phase == GET_CHECK) push_cmd <= cmd_q;
    end

endmodule

//--- verilog/frame_sender.sv
module frame_sender #(
    parameter int byte_gap = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] reply_cmd,
    input  logic       fs_com_send,
    output logic       fd_com_send,
    output logic       tx_valid,
    output logic [7:0] tx_byte
);

    localparam int gap_w = (byte_gap > 0) ? $clog2(byte_gap + 1) : 1;

    logic             active;
    logic [1:0]       byte_cnt;
    logic [gap_w-1:0] gap_cnt;
    logic             emit;

    assign emit = active && (gap_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active      <= 1'b0;
            byte_cnt    <= 2'd0;
            gap_cnt     <= '0;
            tx_valid    <= 1'b0;
            fd_com_send <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            if (emit) begin
                tx_valid <= 1'b1;
                byte_cnt <= byte_cnt + 2'd1;
                gap_cnt  <= gap_w'(byte_gap);
                active   <= (byte_cnt != 2'd2);
            end else if (active) begin
                gap_cnt <= gap_cnt - 1'b1;
            end else if (fs_com_send && byte_cnt == 2'd0) begin
                active  <= 1'b1;
                gap_cnt <= '0;
            end
            // byte_cnt stays at 3 until the request is released, so no restart
            if (tx_valid && byte_cnt == 2'd3) begin
                fd_com_send <= 1'b1;
            end else if (fd_com_send && !fs_com_send) begin
                fd_com_send <= 1'b0;
                byte_cnt    <= 2'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            case (byte_cnt)
                2'd0:    tx_byte <= com_proto_pkg::SYNC_BYTE;
                2'd1:    tx_byte <= reply_cmd;
                default: tx_byte <= ~reply_cmd;
            endcase
        end
    end

endmodule

//--- verilog/reply_builder.sv
module reply_builder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            head_cmd,
    input  logic                  fs_read,
    output logic                  fd_read,
    output logic                  fs_send,
    input  logic                  fd_send,
    output com_proto_pkg::btype_e com_btype,
    output logic [7:0]            reply_cmd
);

    logic [7:0]            cmd_q;
    logic                  busy;
    logic                  reply_due;
    com_proto_pkg::btype_e cmd_type;
    com_proto_pkg::btype_e reply_type;

    assign cmd_type  = com_proto_pkg::btype_e'(cmd_q[7:4]);
    assign reply_cmd = {reply_type, cmd_q[3:0]};  // argument is echoed unchanged
    assign com_btype = busy ? reply_type : com_proto_pkg::btype_e'(head_cmd[7:4]);

    always_comb begin
        reply_type = cmd_type;
        reply_due  = 1'b1;
        case (cmd_type)
            com_proto_pkg::READ: begin
                reply_type = cmd_q[0] ? com_proto_pkg::RXD1 : com_proto_pkg::RXD0;
            end
            com_proto_pkg::RXD0,
            com_proto_pkg::RXD1: reply_due = 1'b0;  // data from the host needs no answer
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!busy && fs_read && !fd_read) cmd_q <= head_cmd;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            fd_read <= 1'b0;
            fs_send <= 1'b0;
        end else begin
            if (!busy && fs_read && !fd_read) begin
                busy    <= 1'b1;
                fd_read <= 1'b1;
            end else if (fd_read && !fs_read) begin
                fd_read <= 1'b0;
                if (reply_due) fs_send <= 1'b1;
                else busy <= 1'b0;
            end
            if (fs_send && fd_send) begin
                fs_send <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

endmodule
